// ==== dv/programVectors.txt ====
// @000 holds the program word count, then the expected report count
// program words from @010; from @100 each line is register and written value
@000
00000018
0000000f
@010
20010005 // addi $1, $0, 5
2002000e // addi $2, $0, 14
00221820 // add $3, $1, $2
00612022 // sub $4, $3, $1
00622824 // and $5, $3, $2
00a13025 // or $6, $5, $1
0083382a // slt $7, $4, $3
2008fffd // addi $8, $0, -3
0101482a // slt $9, $8, $1
0028502a // slt $10, $1, $8
ac030008 // sw $3, 8($0)
8c0b0008 // lw $11, 8($0)
01616020 // add $12, $11, $1
200d0018 // addi $13, $0, 24
11ac0001 // beq $13, $12, +1 (taken)
200e0063 // addi $14, $0, 99 (skipped)
10220001 // beq $1, $2, +1 (not taken)
200f0007 // addi $15, $0, 7
08000015 // j 21
20100001 // addi $16, $0, 1 (skipped)
20110002 // addi $17, $0, 2 (skipped)
20000037 // addi $0, $0, 55 (no report)
01ed9020 // add $18, $15, $13
08000017 // j 23 (halt loop)
@100
01 00000005
02 0000000e
03 00000013
04 0000000e
05 00000002
06 00000007
07 00000001
08 fffffffd
09 00000001
0a 00000000
0b 00000013
0c 00000018
0d 00000018
0f 00000007
12 0000001f

// ==== filelist.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/stageRegister.sv
verilog/executeUnit.sv
verilog/memoryUnit.sv
verilog/pipelineCpu.sv
dv/cpuTb.sv

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module cpuTb;
	import cpuPkg::*;

	// vector file layout, word addresses
	localparam int vecDepth = 512;
	localparam int progBase = 'h10;
	localparam int expBase = 'h100;
	localparam wordT nop = '0;

	logic clk;
	logic reset;
	wordT instrAddr;
	wordT instrData;
	memWbT wbReport;

	logic [31:0] vectors [vecDepth];
	int progWords;
	int expCount;
	int reportIndex;
	int cycleCount;
	int cycleLimit;
	bit timedOut;

	pipelineCpu DUT (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.wbReport(wbReport)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic compareValue(input string what, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// instruction memory model, nop past the end of the program
	task automatic driveInstruction();
		wordT wordIndex;
		wordIndex = instrAddr / `PC_STEP;
		if (wordIndex < progWords)
			instrData = vectors[progBase + wordIndex];
		else
			instrData = nop;
	endtask

	// next expected pair is register then value
	task automatic checkReport();
		wordT expReg;
		wordT expData;
		expReg = vectors[expBase + 2 * reportIndex];
		expData = vectors[expBase + 2 * reportIndex + 1];
		compareValue($sformatf("report %0d register", reportIndex),
			wordT'(wbReport.dest), expReg);
		compareValue($sformatf("report %0d data", reportIndex), wbReport.data, expData);
		reportIndex++;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instrData = nop;
		reportIndex = 0;
		cycleCount = 0;
		timedOut = 1'b0;

		$readmemh("dv/programVectors.txt", vectors);
		if ($isunknown(vectors[0]) || $isunknown(vectors[1]) ||
			vectors[0] > expBase - progBase || 2 * vectors[1] > vecDepth - expBase) begin
			$display("vector file is missing or its word counts do not fit the layout");
			$display("TESTS FAILED");
			$fatal(1, "bad vector file");
		end
		progWords = vectors[0];
		expCount = vectors[1];
		// each instruction a few cycles at most, plus pipeline fill and drain
		cycleLimit = 4 * progWords + 40;

		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		driveInstruction();

		// reports are sampled mid-cycle, away from the register update
		while (reportIndex < expCount && !timedOut) begin
			@(negedge clk);
			if (wbReport.regWrite)
				checkReport();
			driveInstruction();
			cycleCount++;
			if (cycleCount >= cycleLimit && reportIndex < expCount)
				timedOut = 1'b1;
		end

		if (timedOut) begin
			$display("timeout: only %0d of %0d register writes reported after %0d cycles",
				reportIndex, expCount, cycleCount);
			$display("TESTS FAILED");
			$fatal(1, "run did not complete");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== verilog/pipelineCpu.sv ====
`timescale 1ns/1ps

module pipelineCpu (
	input  logic clk,
	input  logic reset,
	output cpuPkg::wordT instrAddr,
	input  cpuPkg::wordT instrData,
	output cpuPkg::memWbT wbReport
);
	import cpuPkg::*;

	wordT pcPlus4;
	wordT target;
	logic stall;
	logic redirect;
	logic squash;
	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;
	memWbT memWbD;
	memWbT memWbQ;

	////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////

	fetchUnit fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.pc(instrAddr),
		.pcPlus4(pcPlus4)
	);

	assign ifIdD = '{pcPlus4: pcPlus4, instr: instrData};

	stageRegister #(.payloadT(ifIdT)) ifIdReg (.clk(clk), .reset(reset), .hold(stall),
		.bubble(squash), .d(ifIdD), .q(ifIdQ));

	// hazard inputs come from the instruction in execute and in memory
	decodeUnit decode (
		.clk(clk),
		.reset(reset),
		.ifId(ifIdQ),
		.exRegWrite(exMemD.regWrite),
		.exMemRead(exMemD.memRead),
		.exDest(exMemD.dest),
		.memDest(exMemQ.dest),
		.memRegWrite(exMemQ.regWrite),
		.writeback(memWbQ),
		.idEx(idExD),
		.stall(stall),
		.redirect(redirect),
		.squash(squash),
		.target(target)
	);

	stageRegister #(.payloadT(idExT)) idExReg (.clk(clk), .reset(reset), .hold(1'b0),
		.bubble(stall), .d(idExD), .q(idExQ));

	////////////////////////////////////////
	// execute, memory and writeback
	////////////////////////////////////////

	executeUnit execute (.idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ), .result(exMemD));

	stageRegister #(.payloadT(exMemT)) exMemReg (.clk(clk), .reset(reset), .hold(1'b0),
		.bubble(1'b0), .d(exMemD), .q(exMemQ));

	memoryUnit memory (.clk(clk), .reset(reset), .exMem(exMemQ), .memWb(memWbD));

	stageRegister #(.payloadT(memWbT)) memWbReg (.clk(clk), .reset(reset), .hold(1'b0),
		.bubble(1'b0), .d(memWbD), .q(memWbQ));

	// register file write port and the external report share one payload
	assign wbReport = memWbQ;

endmodule

// ==== verilog/memoryUnit.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module memoryUnit (
	input  logic clk,
	input  logic reset,
	input  cpuPkg::exMemT exMem,
	output cpuPkg::memWbT memWb
);
	import cpuPkg::*;

	localparam int indexWidth = $clog2(`DMEM_WORDS);

	wordT dataMem [`DMEM_WORDS];
	logic [indexWidth-1:0] wordIndex;
	wordT loadData;

	// byte address to word index
	assign wordIndex = exMem.aluResult[indexWidth+1:2];
	assign loadData = dataMem[wordIndex];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dataMem[i] <= '0;
		end else if (exMem.memWrite) begin
			dataMem[wordIndex] <= exMem.storeData;
		end
	end

	// writes to register 0 are dropped here, so they never report
	assign memWb.regWrite = exMem.regWrite && (exMem.dest != '0);
	assign memWb.data = exMem.memToReg ? loadData : exMem.aluResult;
	assign memWb.dest = exMem.dest;

	assert property (@(posedge clk) disable iff (reset) !(exMem.memRead && exMem.memWrite))
		else $error("load and store controls set together");

endmodule

// ==== verilog/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
	input  cpuPkg::idExT idEx,
	input  cpuPkg::exMemT exMem,
	input  cpuPkg::memWbT memWb,
	output cpuPkg::exMemT result
);
	import cpuPkg::*;

	aluOpT aluOp;
	wordT opA;
	wordT fwdB;
	wordT opB;
	wordT aluOut;
	regAddrT dest;

	////////////////////////////////////////
	// ALU control
	////////////////////////////////////////

	// addi, lw and sw all add
	always_comb begin
		aluOp = aluAdd;
		if (idEx.ctrl.rType) begin
			case (idEx.funct)
				fnAdd: aluOp = aluAdd;
				fnSub: aluOp = aluSub;
				fnAnd: aluOp = aluAnd;
				fnOr: aluOp = aluOr;
				fnSlt: aluOp = aluSlt;
				default: aluOp = aluAdd;
			endcase
		end
	end

	////////////////////////////////////////
	// forwarding
	////////////////////////////////////////

	// youngest producer first
	function automatic wordT forward(regAddrT src, wordT regValue, exMemT mem, memWbT wb);
		if (src == '0)
			return regValue;
		if (mem.regWrite && mem.dest == src)
			return mem.aluResult;
		if (wb.regWrite && wb.dest == src)
			return wb.data;
		return regValue;
	endfunction

	always_comb begin
		opA = forward(idEx.rs, idEx.rsData, exMem, memWb);
		fwdB = forward(idEx.rt, idEx.rtData, exMem, memWb);
	end

	assign opB = idEx.ctrl.aluSrc ? idEx.imm : fwdB;

	////////////////////////////////////////
	// ALU and result
	////////////////////////////////////////

	always_comb begin
		case (aluOp)
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr: aluOut = opA | opB;
			// signed compare, zero-extended flag
			aluSlt: aluOut = wordT'($signed(opA) < $signed(opB));
			default: aluOut = opA + opB;
		endcase
	end

	// rd for register format, rt otherwise
	assign dest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	always_comb begin
		result.regWrite = idEx.ctrl.regWrite;
		result.memRead = idEx.ctrl.memRead;
		result.memWrite = idEx.ctrl.memWrite;
		result.memToReg = idEx.ctrl.memToReg;
		result.aluResult = aluOut;
		result.storeData = fwdB;
		result.dest = dest;
	end

	// decode never pairs an immediate operand with a function-field op
	always_comb begin
		assert #0 (!(idEx.ctrl.aluSrc && idEx.ctrl.rType))
			else $error("immediate operand on register-format instruction");
	end

endmodule

// ==== verilog/stageRegister.sv ====
`timescale 1ns/1ps

module stageRegister #(
	parameter type payloadT = logic
) (
	input  logic clk,
	input  logic reset,
	input  logic hold,
	input  logic bubble,
	input  payloadT d,
	output payloadT q
);

	// an all-zero payload carries no controls, so it acts as a bubble
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q <= '0;
		end else if (bubble) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

	// fetch data and every upstream stage must stay resolved once running
	assert property (@(posedge clk) disable iff (reset) !$isunknown(q))
		else $error("stage register holds unknown bits");

endmodule

// ==== verilog/decodeUnit.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module decodeUnit (
	input  logic clk,
	input  logic reset,
	input  cpuPkg::ifIdT ifId,
	input  logic exRegWrite,
	input  logic exMemRead,
	input  cpuPkg::regAddrT exDest,
	input  cpuPkg::regAddrT memDest,
	input  logic memRegWrite,
	input  cpuPkg::memWbT writeback,
	output cpuPkg::idExT idEx,
	output logic stall,
	output logic redirect,
	output logic squash,
	output cpuPkg::wordT target
);
	import cpuPkg::*;

	wordT regs [`REG_COUNT];
	opcodeT opcode;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	wordT imm;
	wordT rsData;
	wordT rtData;
	wordT branchTarget;
	wordT jumpTarget;
	ctrlT ctrl;
	logic isBeq;
	logic isJump;
	logic usesRs;
	logic usesRt;
	logic loadUse;
	logic branchWait;
	logic taken;

	assign opcode = opcodeT'(ifId.instr[31:26]);
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign imm = {{(`WORD_WIDTH-16){ifId.instr[15]}}, ifId.instr[15:0]};

	////////////////////////////////////////
	// control decode
	////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				ctrl.rType = 1'b1;
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			// beq and j finish here, nothing goes downstream
			default: ctrl = '0;
		endcase
	end

	assign isBeq = (opcode == opBeq);
	assign isJump = (opcode == opJ);
	assign usesRs = !isJump;
	assign usesRt = ctrl.rType || ctrl.memWrite || isBeq;

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	// register 0 is never written, writeback filters it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeback.regWrite) begin
			regs[writeback.dest] <= writeback.data;
		end
	end

	// same-cycle writeback passes straight to the read ports
	function automatic wordT readReg(regAddrT addr);
		if (addr == '0)
			return '0;
		if (writeback.regWrite && writeback.dest == addr)
			return writeback.data;
		return regs[addr];
	endfunction

	always_comb begin
		rsData = readReg(rs);
		rtData = readReg(rt);
	end

	////////////////////////////////////////
	// hazards and redirection
	////////////////////////////////////////

	function automatic logic pending(logic writes, regAddrT dest);
		return writes && (dest != '0) && ((dest == rs) || (dest == rt));
	endfunction

	assign loadUse = exMemRead && (exDest != '0) &&
		((usesRs && exDest == rs) || (usesRt && exDest == rt));
	// beq compares here, so its sources must already be in the file
	always_comb begin
		branchWait = isBeq &&
			(pending(exRegWrite, exDest) || pending(memRegWrite, memDest));
	end
	assign stall = loadUse || branchWait;

	assign taken = isJump || (isBeq && (rsData == rtData));
	assign redirect = taken && !stall;
	assign squash = taken && !stall;

	assign branchTarget = ifId.pcPlus4 + (imm << 2);
	assign jumpTarget = {ifId.pcPlus4[`WORD_WIDTH-1:28], ifId.instr[25:0], 2'b00};
	assign target = isJump ? jumpTarget : branchTarget;

	always_comb begin
		idEx.ctrl = stall ? ctrlT'('0) : ctrl;
		idEx.rsData = rsData;
		idEx.rtData = rtData;
		idEx.imm = imm;
		idEx.rs = rs;
		idEx.rt = rt;
		idEx.rd = rd;
		idEx.funct = ifId.instr[5:0];
	end

	// the squashed slot reaches decode as a bubble
	assert property (@(posedge clk) disable iff (reset) redirect |=> ifId == '0)
		else $error("wrongly fetched instruction reached decode after a redirect");

endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps
`include "cpuMacros.svh"

module fetchUnit (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic redirect,
	input  cpuPkg::wordT target,
	output cpuPkg::wordT pc,
	output cpuPkg::wordT pcPlus4
);
	import cpuPkg::*;

	// sequential successor, also carried to decode for branch targets
	assign pcPlus4 = pc + wordT'(`PC_STEP);

	// redirect wins; decode never raises it while stalled
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= target;
		end else if (!stall) begin
			pc <= pcPlus4;
		end
	end

	// targets from decode must keep the fetch address on a word boundary
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("fetch address %h not word aligned", pc);

endmodule

// ==== verilog/cpuPkg.sv ====
`include "cpuMacros.svh"

package cpuPkg;

	typedef logic [`WORD_WIDTH-1:0] wordT;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// function field of register-format words
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} funcT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		logic regDst;
		// ALU operation comes from the function field
		logic rType;
	} ctrlT;

	typedef struct packed {
		wordT pcPlus4;
		wordT instr;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT rsData;
		wordT rtData;
		wordT imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		logic [5:0] funct;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		wordT aluResult;
		wordT storeData;
		regAddrT dest;
	} exMemT;

	// also the writeback report at the top level
	typedef struct packed {
		logic regWrite;
		wordT data;
		regAddrT dest;
	} memWbT;

endpackage

// ==== verilog/cpuMacros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// data word and byte address width
`define WORD_WIDTH 32

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

////////////////////////////////////////
// memories and sequencing
////////////////////////////////////////

// data memory depth in words
`define DMEM_WORDS 64

// byte step between sequential instructions
`define PC_STEP 4

`endif
